// ==== hdl/merge_settings.svh ====
// merge settings: payload width, input count and source index width for the priority merge

`ifndef MERGE_SETTINGS_SVH
`define MERGE_SETTINGS_SVH

// width of one payload word on every input stream
`define MERGE_WORD_WIDTH 16

// number of input streams merged into the single output stream
`define MERGE_INPUT_COUNT 4

// width of the source tag, wide enough to name every input
// keep this in step with MERGE_INPUT_COUNT when the count changes
`define MERGE_SOURCE_WIDTH 2

`endif

// ==== hdl/merge_pkg.sv ====
// merge package: payload, source index and tagged output record types for the priority merge

`include "merge_settings.svh"

package merge_pkg;

    // one payload word as it arrives on an input stream
    typedef logic [`MERGE_WORD_WIDTH-1:0] word_t;

    // index of the input a word came from
    typedef logic [`MERGE_SOURCE_WIDTH-1:0] source_t;

    // record on the output side
    // the source sits in the upper bits so the data field lines up with the input word
    typedef struct packed {
        source_t source;
        word_t   data;
    } merged_t;

endpackage

// ==== hdl/pipeline_skid_buffer.sv ====
// skid buffer: two-entry ready/valid register stage that breaks the valid-to-ready path
`timescale 1ns/1ps

module pipeline_skid_buffer
    import merge_pkg::*;
#(
    parameter type payload_t = word_t
) (
    input  logic     clock,
    input  logic     rst,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // empty holds nothing, busy holds one word in main, full holds main and skid
    typedef enum logic [1:0] {
        state_empty,
        state_busy,
        state_full
    } state_t;

    state_t   state;
    state_t   state_next;
    payload_t main_data;
    payload_t skid_data;
    logic     insert;
    logic     remove;
    logic     load_main;
    logic     load_skid;
    logic     unload_skid;

    // a transfer happens on each side only when both handshake signals are high
    assign insert = in_valid && in_ready;
    assign remove = out_valid && out_ready;

    // the next state depends only on the two transfers, and the load enables follow from it
    always_comb begin
        state_next  = state;
        load_main   = 1'b0;
        load_skid   = 1'b0;
        unload_skid = 1'b0;
        case (state)
            state_empty: begin
                if (insert) begin
                    state_next = state_busy;
                    load_main  = 1'b1;
                end
            end
            state_busy: begin
                if (insert && !remove) begin
                    // output stalled, so the new word goes to the skid register
                    state_next = state_full;
                    load_skid  = 1'b1;
                end else if (insert && remove) begin
                    // word streams straight through the main register
                    load_main = 1'b1;
                end else if (remove) begin
                    state_next = state_empty;
                end
            end
            state_full: begin
                // in_ready is low here, so only the output side can move
                if (remove) begin
                    state_next  = state_busy;
                    unload_skid = 1'b1;
                end
            end
            default: begin
                state_next = state_empty;
            end
        endcase
    end

    // both handshake outputs come from flops loaded from the next state
    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= state_empty;
            in_ready  <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            state     <= state_next;
            in_ready  <= (state_next != state_full);
            out_valid <= (state_next != state_empty);
        end
    end

    always_ff @(posedge clock) begin
        if (load_main) begin
            main_data <= in_data;
        end else if (unload_skid) begin
            main_data <= skid_data;
        end
        if (load_skid) begin
            skid_data <= in_data;
        end
    end

    // the output is always the main register
    assign out_data = main_data;

    // the registered ready must have fallen one edge before the buffer filled
    assert property (@(posedge clock) disable iff (rst)
        (state == state_full) |-> !insert)
        else $error("skid buffer accepted a word while full");

    // a stalled word is held until the receiver takes it
    assert property (@(posedge clock) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("skid buffer changed a stalled output word");

endmodule

// ==== hdl/arbiter_priority.sv ====
// priority arbiter: grants the lowest-index request and holds the grant while it stays asserted
`timescale 1ns/1ps

module arbiter_priority #(
    parameter int input_count = 2
) (
    input  logic                   clock,
    input  logic                   rst,
    input  logic [input_count-1:0] requests,
    output logic [input_count-1:0] grant
);

    logic [input_count-1:0] grant_held;
    logic [input_count-1:0] grant_lowest;
    logic                   hold;

    // isolate the lowest set bit of the requests
    // adding one to the inverse carries up to exactly that bit
    assign grant_lowest = requests & (~requests + 1'b1);

    // the previous winner keeps its turn for as long as it keeps asking
    assign hold = |(grant_held & requests);

    // grant_held is one-hot or zero, so masking it with requests gives it back unchanged on hold
    assign grant = hold ? grant_held : grant_lowest;

    // remember the winner for the next cycle
    // a zero grant clears the hold so the next request starts a fresh choice
    always_ff @(posedge clock) begin
        if (rst) begin
            grant_held <= '0;
        end else begin
            grant_held <= grant;
        end
    end

    // at most one requester wins at any time
    assert property (@(posedge clock) disable iff (rst)
        $onehot0(grant))
        else $error("arbiter grant is not one-hot");

    // a grant never goes to an input that is not asking
    assert property (@(posedge clock) disable iff (rst)
        (grant & ~requests) == '0)
        else $error("arbiter granted an idle request");

endmodule

// ==== hdl/pipeline_merge_priority.sv ====
// priority merge: arbitrates buffered inputs, selects and tags the granted word, steers ready back
`timescale 1ns/1ps

`include "merge_settings.svh"

module pipeline_merge_priority
    import merge_pkg::*;
(
    input  logic                          clock,
    input  logic                          rst,

    input  logic [`MERGE_INPUT_COUNT-1:0] buf_valid,
    output logic [`MERGE_INPUT_COUNT-1:0] buf_ready,
    input  word_t                         buf_data [`MERGE_INPUT_COUNT],

    output logic                          merge_valid,
    input  logic                          merge_ready,
    output merged_t                       merge_data
);

    logic [`MERGE_INPUT_COUNT-1:0] grant;
    word_t                         sel_word;
    source_t                       sel_source;

    // any waiting input makes the output valid
    // the arbiter always grants one of them, so the offered word is never empty
    assign merge_valid = |buf_valid;

    // pick one of the valid inputs, lowest index first, holding the pick under stall
    arbiter_priority #(
        .input_count (`MERGE_INPUT_COUNT)
    ) u_arbiter (
        .clock    (clock),
        .rst      (rst),
        .requests (buf_valid),
        .grant    (grant)
    );

    // one-hot AND-OR select of the granted word
    // the same loop encodes the grant bit into its index
    always_comb begin
        sel_word   = '0;
        sel_source = '0;
        for (int i = 0; i < `MERGE_INPUT_COUNT; i++) begin
            sel_word = sel_word | (buf_data[i] & {`MERGE_WORD_WIDTH{grant[i]}});
            if (grant[i]) begin
                sel_source = sel_source | source_t'(i);
            end
        end
    end

    // tag the word with the input it came from
    assign merge_data.source = sel_source;
    assign merge_data.data   = sel_word;

    // only the granted input sees the downstream ready
    // the other inputs keep their words and wait
    assign buf_ready = grant & {`MERGE_INPUT_COUNT{merge_ready}};

    // the input buffers hold a stalled word and the arbiter holds its grant,
    // so the merged word cannot change until it is taken
    assert property (@(posedge clock) disable iff (rst)
        (merge_valid && !merge_ready) |=> (merge_valid && $stable(merge_data)))
        else $error("merged word changed while stalled");

endmodule

// ==== hdl/merge_subsystem_top.sv ====
// merge subsystem: buffered inputs, priority merge and buffered tagged output
`timescale 1ns/1ps

`include "merge_settings.svh"

module merge_subsystem_top
    import merge_pkg::*;
(
    input  logic                          clock,
    input  logic                          rst,

    input  logic [`MERGE_INPUT_COUNT-1:0] in_valid,
    output logic [`MERGE_INPUT_COUNT-1:0] in_ready,
    input  word_t                         in_data [`MERGE_INPUT_COUNT],

    output logic                          out_valid,
    input  logic                          out_ready,
    output merged_t                       out_data
);

    logic [`MERGE_INPUT_COUNT-1:0] buf_valid;
    logic [`MERGE_INPUT_COUNT-1:0] buf_ready;
    word_t                         buf_data [`MERGE_INPUT_COUNT];
    logic                          merge_valid;
    logic                          merge_ready;
    merged_t                       merge_data;

    // every input gets its own skid buffer so no input ready depends on its valid
    for (genvar i = 0; i < `MERGE_INPUT_COUNT; i++) begin : g_input
        pipeline_skid_buffer #(
            .payload_t (word_t)
        ) u_in_buffer (
            .clock     (clock),
            .rst       (rst),
            .in_valid  (in_valid[i]),
            .in_ready  (in_ready[i]),
            .in_data   (in_data[i]),
            .out_valid (buf_valid[i]),
            .out_ready (buf_ready[i]),
            .out_data  (buf_data[i])
        );
    end

    pipeline_merge_priority u_merge (
        .clock       (clock),
        .rst         (rst),
        .buf_valid   (buf_valid),
        .buf_ready   (buf_ready),
        .buf_data    (buf_data),
        .merge_valid (merge_valid),
        .merge_ready (merge_ready),
        .merge_data  (merge_data)
    );

    // the output buffer also cuts the path from out_ready back to in_ready
    pipeline_skid_buffer #(
        .payload_t (merged_t)
    ) u_out_buffer (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (merge_valid),
        .in_ready  (merge_ready),
        .in_data   (merge_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
// testbench clock and reset generator: free-running clock with a synchronous reset held after start
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 10
) (
    output logic clock,
    output logic rst
);

    // the clock starts low so the first rising edge lands half a period in
    initial begin
        clock = 1'b0;
        forever #(period_ns / 2.0) clock = ~clock;
    end

    // reset is released on a rising edge, like any other synchronous input
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        rst <= 1'b0;
    end

endmodule

// ==== dv/merge_tb.sv ====
// merge testbench: directed and random traffic through the priority merge with a per-source scoreboard
`timescale 1ns/1ps

`include "merge_settings.svh"

module merge_tb
    import merge_pkg::*;
();

    localparam int input_count = `MERGE_INPUT_COUNT;
    localparam int cycle_limit = 2000;
    localparam int wait_limit  = 40;

    logic                   clock;
    logic                   rst;
    logic [input_count-1:0] in_valid;
    logic [input_count-1:0] in_ready;
    word_t                  in_data [input_count];
    logic                   out_valid;
    logic                   out_ready;
    merged_t                out_data;

    // one queue of accepted words per input, drained in order as tagged words leave
    word_t       expected_words [input_count][$];
    source_t     delivered_sources [$];
    int          delivered_count = 0;
    int          cycle_count = 0;

    tb_clock_gen #(
        .period_ns    (8),
        .reset_cycles (10)
    ) u_clock_gen (
        .clock (clock),
        .rst   (rst)
    );

    merge_subsystem_top u_dut (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("MISMATCH at time %0t: %s expected 0x%0h, actual 0x%0h",
                                $time, name, expected, actual));
        end
    endtask

    // the whole run is bounded by the sum of the test lengths plus a wide margin
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run($sformatf("timeout, the run went past %0d clock cycles", cycle_limit));
        end
    end

    // handshakes are sampled at the falling edge, half a cycle after the drivers settle
    // a transfer seen here completes on the following rising edge
    always @(negedge clock) begin
        source_t seen_source;
        word_t   expected_word;
        if (!rst) begin
            for (int i = 0; i < input_count; i++) begin
                if (in_valid[i] && in_ready[i]) begin
                    expected_words[i].push_back(in_data[i]);
                end
            end
            if (out_valid && out_ready) begin
                seen_source = out_data.source;
                if (expected_words[seen_source].size() == 0) begin
                    abort_run($sformatf("source %0d delivered a word it never accepted",
                                        seen_source));
                end else begin
                    expected_word = expected_words[seen_source].pop_front();
                    compare_values("out_data.data", expected_word, out_data.data);
                    delivered_sources.push_back(seen_source);
                    delivered_count++;
                end
            end
        end
    end

    // polls on rising edges until the scoreboard has seen the given number of output words
    task automatic wait_for_delivered(input int target);
        int waited;
        waited = 0;
        while (delivered_count < target) begin
            @(posedge clock);
            waited++;
            if (waited > wait_limit) begin
                abort_run($sformatf("only %0d of %0d output words arrived in time",
                                    delivered_count, target));
            end
        end
    endtask

    // an idle subsystem offers nothing and can take a word on every input
    task automatic check_idle_after_reset();
        @(negedge clock);
        compare_values("out_valid", 0, out_valid);
        compare_values("in_ready", {input_count{1'b1}}, in_ready);
        $display("reset state test done");
    endtask

    // one word per input with the output open, each leaving two edges after it was taken
    task automatic send_one_word_per_input();
        word_t word;
        int    accept_cycle;
        int    waited;
        @(posedge clock);
        out_ready <= 1'b1;
        for (int i = 0; i < input_count; i++) begin
            word = word_t'(16'h2000 + 16'h0111 * i);
            @(posedge clock);
            in_valid[i] <= 1'b1;
            in_data[i]  <= word;
            waited = 0;
            do begin
                @(negedge clock);
                waited++;
                if (waited > wait_limit) begin
                    abort_run($sformatf("input %0d never accepted its word", i));
                end
            end while (!(in_valid[i] && in_ready[i]));
            accept_cycle = cycle_count;
            @(posedge clock);
            in_valid[i] <= 1'b0;
            waited = 0;
            do begin
                @(negedge clock);
                waited++;
                if (waited > wait_limit) begin
                    abort_run($sformatf("the word sent on input %0d never came out", i));
                end
            end while (!(out_valid && out_ready));
            // one edge into the input buffer, one into the output buffer, then out
            compare_values("output latency in cycles", 2, cycle_count - accept_cycle);
            compare_values("out_data.source", i, out_data.source);
            compare_values("out_data.data", word, out_data.data);
        end
        $display("single word test done");
    endtask

    // four words loaded under stall, one per cycle in the order 3, 1, 2, 0
    task automatic release_stalled_words();
        int                     load_order [4] = '{3, 1, 2, 0};
        int                     leave_order [4] = '{3, 1, 2, 0};
        logic [input_count-1:0] one_hot;
        int                     waited;
        @(posedge clock);
        out_ready <= 1'b0;
        delivered_sources.delete();
        for (int k = 0; k < 4; k++) begin
            one_hot = '0;
            one_hot[load_order[k]] = 1'b1;
            @(posedge clock);
            in_valid <= one_hot;
            in_data[load_order[k]] <= word_t'(16'h3000 + load_order[k]);
            @(negedge clock);
            compare_values($sformatf("in_ready[%0d]", load_order[k]), 1, in_ready[load_order[k]]);
        end
        @(posedge clock);
        in_valid <= '0;
        repeat (4) @(posedge clock);
        // the empty output buffer took input 3 and then input 1 before it filled
        // input 2 was alone when it won, and the hold keeps it ahead of input 0
        @(negedge clock);
        compare_values("out_valid", 1, out_valid);
        compare_values("out_data.source", 3, out_data.source);
        @(posedge clock);
        out_ready <= 1'b1;
        waited = 0;
        while (delivered_sources.size() < 4) begin
            @(posedge clock);
            waited++;
            if (waited > wait_limit) begin
                abort_run("the four stalled words did not all leave after the stall ended");
            end
        end
        for (int k = 0; k < 4; k++) begin
            compare_values($sformatf("source of output word %0d", k), leave_order[k],
                           delivered_sources[k]);
        end
        $display("stalled priority test done");
    endtask

    // one input fed without a break under stall, filling both buffers on its path
    task automatic fill_under_backpressure();
        int   accepted;
        int   idle;
        int   cycles;
        int   waited;
        int   base;
        logic took;
        base = delivered_count;
        accepted = 0;
        idle = 0;
        cycles = 0;
        @(posedge clock);
        out_ready   <= 1'b0;
        in_valid[2] <= 1'b1;
        in_data[2]  <= word_t'(16'h4000);
        while (idle < 6) begin
            @(negedge clock);
            took = in_valid[2] && in_ready[2];
            if (took) begin
                accepted++;
                idle = 0;
            end else begin
                idle++;
            end
            cycles++;
            if (cycles > wait_limit) begin
                abort_run("input 2 kept taking words while the output was stalled");
            end
            @(posedge clock);
            if (took) begin
                in_data[2] <= word_t'(16'h4000 + accepted);
            end
        end
        compare_values("words taken by input 2 under stall", 4, accepted);
        // the fifth word stays offered and goes in once the stall ends
        out_ready <= 1'b1;
        took = 1'b0;
        waited = 0;
        while (!took) begin
            @(negedge clock);
            took = in_valid[2] && in_ready[2];
            waited++;
            if (waited > wait_limit) begin
                abort_run("input 2 never took its held word after the stall ended");
            end
        end
        @(posedge clock);
        in_valid[2] <= 1'b0;
        wait_for_delivered(base + 5);
        $display("back-pressure depth test done");
    endtask

    // random valids, data and output ready, with each offered word held until taken
    task automatic run_random_traffic();
        logic [input_count-1:0] offering;
        logic [input_count-1:0] took;
        int                     waited;
        int                     pending;
        offering = '0;
        took = '0;
        for (int cycle = 0; cycle < 600; cycle++) begin
            @(posedge clock);
            for (int i = 0; i < input_count; i++) begin
                if (!offering[i] || took[i]) begin
                    offering[i] = $urandom % 2;
                    in_valid[i] <= offering[i];
                    in_data[i]  <= word_t'($urandom);
                end
            end
            out_ready <= ($urandom % 4) != 0;
            @(negedge clock);
            took = in_valid & in_ready;
        end
        // words still offered are left in place until taken, then withdrawn
        waited = 0;
        while (offering != '0) begin
            @(posedge clock);
            offering = offering & ~took;
            in_valid  <= offering;
            out_ready <= 1'b1;
            @(negedge clock);
            took = in_valid & in_ready;
            waited++;
            if (waited > wait_limit) begin
                abort_run("random traffic left an input word that was never taken");
            end
        end
        waited = 0;
        do begin
            @(negedge clock);
            pending = 0;
            for (int i = 0; i < input_count; i++) begin
                pending += expected_words[i].size();
            end
            waited++;
            if (waited > wait_limit) begin
                abort_run($sformatf("%0d accepted words never came out", pending));
            end
        end while (pending != 0 || out_valid);
        $display("random traffic test done, %0d words delivered", delivered_count);
    endtask

    initial begin
        void'($urandom(76));
        in_valid  = '0;
        out_ready = 1'b0;
        for (int i = 0; i < input_count; i++) begin
            in_data[i] = '0;
        end
        @(posedge clock);
        while (rst) begin
            @(posedge clock);
        end
        check_idle_after_reset();
        send_one_word_per_input();
        release_stalled_words();
        fill_under_backpressure();
        run_random_traffic();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/merge_pkg.sv
hdl/pipeline_skid_buffer.sv
hdl/arbiter_priority.sv
hdl/pipeline_merge_priority.sv
hdl/merge_subsystem_top.sv
dv/tb_clock_gen.sv
dv/merge_tb.sv

// ==== Bender.yml ====
package:
  name: merge_subsystem

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/merge_pkg.sv
      - hdl/pipeline_skid_buffer.sv
      - hdl/arbiter_priority.sv
      - hdl/pipeline_merge_priority.sv
      - hdl/merge_subsystem_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/tb_clock_gen.sv
      - dv/merge_tb.sv
